/* common/scpad_types_pkg.sv */
package scpad_types_pkg;

    // scratchpad row geometry
    localparam int ROW_BYTES = 8;
    localparam int ROW_WIDTH = ROW_BYTES * 8;
    localparam int ROW_COUNT = 16;
    localparam int ROW_IDX_WIDTH = $clog2(ROW_COUNT);

    // byte count must hold a full row, so 0..8
    localparam int NUM_BYTES_WIDTH = 4;

    // dram byte address
    localparam int DRAM_ADDR_WIDTH = 32;

    // request ids, one per latch set in the write queue
    localparam int REQ_ID_COUNT = 8;
    localparam int REQ_ID_WIDTH = $clog2(REQ_ID_COUNT);

    // occupancy of the order ring, 0..REQ_ID_COUNT
    localparam int RING_CNT_WIDTH = REQ_ID_WIDTH + 1;

    // read strobe to read data, fixed by the two register stages in scpad_sram
    localparam int SRAM_RD_LATENCY = 2;

    // spill opcodes
    // OP_SPILL copies an sram row out to dram
    // OP_SPILL_ZERO writes zeros and skips the array read
    typedef enum logic {
        OP_SPILL      = 1'b0,
        OP_SPILL_ZERO = 1'b1
    } scpad_op_t;

    // payload of one write-request latch set
    // valid bit lives apart from this so it can be reset on its own
    typedef struct packed {
        logic [DRAM_ADDR_WIDTH-1:0] dram_addr;
        logic [NUM_BYTES_WIDTH-1:0] num_bytes;
        logic [ROW_WIDTH-1:0]       wdata;
    } wr_entry_t;

    // all zero row, used for zero spills
    localparam logic [ROW_WIDTH-1:0] ZERO_ROW = '0;

endpackage

/* hdl/scpad_sram.sv */
`timescale 1ns/10ps

module scpad_sram (
    input  logic                                         clk,
    input  logic                                         n_rst,
    input  logic                                         sram_wr,
    input  logic [scpad_types_pkg::ROW_IDX_WIDTH-1:0]    sram_wr_row,
    input  logic [scpad_types_pkg::ROW_WIDTH-1:0]        sram_wr_data,
    input  logic                                         rd_strobe,
    input  logic [scpad_types_pkg::ROW_IDX_WIDTH-1:0]    rd_row,
    input  logic [scpad_types_pkg::REQ_ID_WIDTH-1:0]     rd_id,
    input  logic [scpad_types_pkg::DRAM_ADDR_WIDTH-1:0]  rd_dram_addr,
    input  logic [scpad_types_pkg::NUM_BYTES_WIDTH-1:0]  rd_num_bytes,
    input  scpad_types_pkg::scpad_op_t                   rd_op,
    output logic                                         rd_done,
    output logic [scpad_types_pkg::REQ_ID_WIDTH-1:0]     done_id,
    output logic [scpad_types_pkg::DRAM_ADDR_WIDTH-1:0]  done_dram_addr,
    output logic [scpad_types_pkg::NUM_BYTES_WIDTH-1:0]  done_num_bytes,
    output logic [scpad_types_pkg::ROW_WIDTH-1:0]        done_rdata
);

    // row array
    logic [scpad_types_pkg::ROW_WIDTH-1:0] mem [scpad_types_pkg::ROW_COUNT];

    // first pipeline stage
    logic                                        s1_valid;
    logic [scpad_types_pkg::REQ_ID_WIDTH-1:0]    s1_id;
    logic [scpad_types_pkg::DRAM_ADDR_WIDTH-1:0] s1_dram_addr;
    logic [scpad_types_pkg::NUM_BYTES_WIDTH-1:0] s1_num_bytes;
    logic [scpad_types_pkg::ROW_WIDTH-1:0]       s1_rdata;

    // host write port
    // nonblocking, so a read of the same row this edge sees the old contents
    always_ff @(posedge clk) begin
        if (sram_wr) begin
            mem[sram_wr_row] <= sram_wr_data;
        end
    end

    // strobes through both stages
    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            s1_valid <= 1'b0;
            rd_done  <= 1'b0;
        end else begin
            s1_valid <= rd_strobe;
            rd_done  <= s1_valid;
        end
    end

    // request fields ride along with the array data
    always_ff @(posedge clk) begin
        if (rd_strobe) begin
            s1_id        <= rd_id;
            s1_dram_addr <= rd_dram_addr;
            s1_num_bytes <= rd_num_bytes;
            // zero spill never looks at the array
            if (rd_op == scpad_types_pkg::OP_SPILL_ZERO) begin
                s1_rdata <= scpad_types_pkg::ZERO_ROW;
            end else begin
                s1_rdata <= mem[rd_row];
            end
        end
        if (s1_valid) begin
            done_id        <= s1_id;
            done_dram_addr <= s1_dram_addr;
            done_num_bytes <= s1_num_bytes;
            done_rdata     <= s1_rdata;
        end
    end

endmodule

/* hdl/spill_req_gen.sv */
`timescale 1ns/10ps

module spill_req_gen (
    input  logic                                         clk,
    input  logic                                         n_rst,
    // host command
    input  logic                                         cmd_valid,
    input  scpad_types_pkg::scpad_op_t                   cmd_op,
    input  logic [scpad_types_pkg::ROW_IDX_WIDTH-1:0]    cmd_row,
    input  logic [scpad_types_pkg::DRAM_ADDR_WIDTH-1:0]  cmd_dram_addr,
    input  logic [scpad_types_pkg::NUM_BYTES_WIDTH-1:0]  cmd_num_bytes,
    output logic                                         spill_busy,
    // sram read port
    output logic                                         rd_strobe,
    output logic [scpad_types_pkg::ROW_IDX_WIDTH-1:0]    rd_row,
    output logic [scpad_types_pkg::REQ_ID_WIDTH-1:0]     rd_id,
    output logic [scpad_types_pkg::DRAM_ADDR_WIDTH-1:0]  rd_dram_addr,
    output logic [scpad_types_pkg::NUM_BYTES_WIDTH-1:0]  rd_num_bytes,
    output scpad_types_pkg::scpad_op_t                   rd_op,
    // id return from the write queue
    input  logic                                         id_free,
    input  logic [scpad_types_pkg::REQ_ID_WIDTH-1:0]     free_id
);

    // one bit per request id, set from allocation until dram acceptance
    logic [scpad_types_pkg::REQ_ID_COUNT-1:0] in_use;
    logic [scpad_types_pkg::REQ_ID_COUNT-1:0] in_use_nxt;

    // lowest clear bit of in_use
    logic [scpad_types_pkg::REQ_ID_WIDTH-1:0] alloc_id;

    // priority pick, scanning down so the lowest free id wins
    always_comb begin
        alloc_id = '0;
        for (int i = scpad_types_pkg::REQ_ID_COUNT - 1; i >= 0; i--) begin
            if (!in_use[i]) begin
                alloc_id = i[scpad_types_pkg::REQ_ID_WIDTH-1:0];
            end
        end
    end

    // every id out, counting reads still in flight
    assign spill_busy = &in_use;

    // free and allocate never hit the same bit
    // the freed id is still marked in_use when the pick is made
    always_comb begin
        in_use_nxt = in_use;
        if (id_free) begin
            in_use_nxt[free_id] = 1'b0;
        end
        if (cmd_valid) begin
            in_use_nxt[alloc_id] = 1'b1;
        end
    end

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            in_use    <= '0;
            rd_strobe <= 1'b0;
        end else begin
            in_use    <= in_use_nxt;
            rd_strobe <= cmd_valid;
        end
    end

    // read port fields, registered with the strobe
    always_ff @(posedge clk) begin
        if (cmd_valid) begin
            rd_row       <= cmd_row;
            rd_id        <= alloc_id;
            rd_dram_addr <= cmd_dram_addr;
            rd_num_bytes <= cmd_num_bytes;
            rd_op        <= cmd_op;
        end
    end

    // host has to hold off while busy, otherwise an in-use id is handed out twice
    cmd_while_busy: assert property (
        @(posedge clk) disable iff (!n_rst)
        cmd_valid |-> !spill_busy
    ) else $error("spill command issued while spill_busy is high");

    // queue may only hand back ids this block gave out
    free_unused_id: assert property (
        @(posedge clk) disable iff (!n_rst)
        id_free |-> in_use[free_id]
    ) else $error("id_free for request id %0d which is not in use", free_id);

endmodule

/* dram_wr_queue/dram_write_request_queue.sv */
`timescale 1ns/10ps

module dram_write_request_queue (
    input  logic                                         clk,
    input  logic                                         n_rst,
    // returned sram reads
    input  logic                                         rd_done,
    input  logic [scpad_types_pkg::REQ_ID_WIDTH-1:0]     done_id,
    input  logic [scpad_types_pkg::DRAM_ADDR_WIDTH-1:0]  done_dram_addr,
    input  logic [scpad_types_pkg::NUM_BYTES_WIDTH-1:0]  done_num_bytes,
    input  logic [scpad_types_pkg::ROW_WIDTH-1:0]        done_rdata,
    // dram write side
    input  logic                                         dram_wr_req_accepted,
    output logic                                         dram_write_req,
    output logic [scpad_types_pkg::DRAM_ADDR_WIDTH-1:0]  dram_addr,
    output logic [scpad_types_pkg::NUM_BYTES_WIDTH-1:0]  dram_num_bytes,
    output logic [scpad_types_pkg::ROW_WIDTH-1:0]        dram_wdata,
    // id return to the generator
    output logic                                         id_free,
    output logic [scpad_types_pkg::REQ_ID_WIDTH-1:0]     free_id
);

    // latch sets, indexed by request id
    scpad_types_pkg::wr_entry_t entries [scpad_types_pkg::REQ_ID_COUNT];
    logic [scpad_types_pkg::REQ_ID_COUNT-1:0] set_valid;
    logic [scpad_types_pkg::REQ_ID_COUNT-1:0] set_valid_nxt;

    // order ring
    // ids come back out of sequence, the ring keeps command order
    logic [scpad_types_pkg::REQ_ID_WIDTH-1:0]   ring [scpad_types_pkg::REQ_ID_COUNT];
    logic [scpad_types_pkg::REQ_ID_WIDTH-1:0]   head_ptr;
    logic [scpad_types_pkg::REQ_ID_WIDTH-1:0]   tail_ptr;
    logic [scpad_types_pkg::RING_CNT_WIDTH-1:0] occupancy;

    // id of the oldest outstanding request
    logic [scpad_types_pkg::REQ_ID_WIDTH-1:0] head_id;

    logic push;
    logic pop;

    assign head_id = ring[head_ptr];
    assign push    = rd_done;
    // strobe only counts while something is presented
    assign pop     = dram_wr_req_accepted && dram_write_req;

    // head presentation, straight off registered state
    assign dram_write_req = (occupancy != '0);
    assign dram_addr      = entries[head_id].dram_addr;
    assign dram_num_bytes = entries[head_id].num_bytes;
    assign dram_wdata     = entries[head_id].wdata;

    // clear popped set first, arrival after
    // arrival id cannot equal head id, that id is only returned a cycle later
    always_comb begin
        set_valid_nxt = set_valid;
        if (pop) begin
            set_valid_nxt[head_id] = 1'b0;
        end
        if (push) begin
            set_valid_nxt[done_id] = 1'b1;
        end
    end

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            set_valid <= '0;
            head_ptr  <= '0;
            tail_ptr  <= '0;
            occupancy <= '0;
            id_free   <= 1'b0;
            free_id   <= '0;
        end else begin
            set_valid <= set_valid_nxt;
            // pointers wrap at REQ_ID_COUNT on their own
            if (push) begin
                tail_ptr <= tail_ptr + 1'b1;
            end
            if (pop) begin
                head_ptr <= head_ptr + 1'b1;
            end
            // push and pop together leave occupancy alone
            case ({push, pop})
                2'b10:   occupancy <= occupancy + 1'b1;
                2'b01:   occupancy <= occupancy - 1'b1;
                default: occupancy <= occupancy;
            endcase
            // id goes back one cycle after acceptance
            id_free <= pop;
            if (pop) begin
                free_id <= head_id;
            end
        end
    end

    // latch set payload and ring slot
    always_ff @(posedge clk) begin
        if (push) begin
            entries[done_id].dram_addr <= done_dram_addr;
            entries[done_id].num_bytes <= done_num_bytes;
            entries[done_id].wdata     <= done_rdata;
            ring[tail_ptr]             <= done_id;
        end
    end

    // overflow, the generator's busy level should make this impossible
    arrival_on_valid_set: assert property (
        @(posedge clk) disable iff (!n_rst)
        rd_done |-> !set_valid[done_id]
    ) else $error("sram read returned for latch set %0d which is still valid", done_id);

    // dram side acknowledged something that was never offered
    accept_without_req: assert property (
        @(posedge clk) disable iff (!n_rst)
        dram_wr_req_accepted |-> dram_write_req
    ) else $error("dram acceptance strobe while dram_write_req is low");

endmodule

/* hdl/scpad_backend.sv */
`timescale 1ns/10ps

module scpad_backend (
    input  logic                                         clk,
    input  logic                                         n_rst,
    // host commands
    input  logic                                         cmd_valid,
    input  scpad_types_pkg::scpad_op_t                   cmd_op,
    input  logic [scpad_types_pkg::ROW_IDX_WIDTH-1:0]    cmd_row,
    input  logic [scpad_types_pkg::DRAM_ADDR_WIDTH-1:0]  cmd_dram_addr,
    input  logic [scpad_types_pkg::NUM_BYTES_WIDTH-1:0]  cmd_num_bytes,
    output logic                                         spill_busy,
    // host row writes
    input  logic                                         sram_wr,
    input  logic [scpad_types_pkg::ROW_IDX_WIDTH-1:0]    sram_wr_row,
    input  logic [scpad_types_pkg::ROW_WIDTH-1:0]        sram_wr_data,
    // dram write side
    output logic                                         dram_write_req,
    output logic [scpad_types_pkg::DRAM_ADDR_WIDTH-1:0]  dram_addr,
    output logic [scpad_types_pkg::NUM_BYTES_WIDTH-1:0]  dram_num_bytes,
    output logic [scpad_types_pkg::ROW_WIDTH-1:0]        dram_wdata,
    input  logic                                         dram_wr_req_accepted
);

    // generator to sram
    logic                                        rd_strobe;
    logic [scpad_types_pkg::ROW_IDX_WIDTH-1:0]   rd_row;
    logic [scpad_types_pkg::REQ_ID_WIDTH-1:0]    rd_id;
    logic [scpad_types_pkg::DRAM_ADDR_WIDTH-1:0] rd_dram_addr;
    logic [scpad_types_pkg::NUM_BYTES_WIDTH-1:0] rd_num_bytes;
    scpad_types_pkg::scpad_op_t                  rd_op;

    // sram to queue
    logic                                        rd_done;
    logic [scpad_types_pkg::REQ_ID_WIDTH-1:0]    done_id;
    logic [scpad_types_pkg::DRAM_ADDR_WIDTH-1:0] done_dram_addr;
    logic [scpad_types_pkg::NUM_BYTES_WIDTH-1:0] done_num_bytes;
    logic [scpad_types_pkg::ROW_WIDTH-1:0]       done_rdata;

    // queue back to generator
    logic                                        id_free;
    logic [scpad_types_pkg::REQ_ID_WIDTH-1:0]    free_id;

    spill_req_gen i_spill_req_gen (
        .clk, .n_rst,
        .cmd_valid, .cmd_op, .cmd_row, .cmd_dram_addr, .cmd_num_bytes,
        .spill_busy,
        .rd_strobe, .rd_row, .rd_id, .rd_dram_addr, .rd_num_bytes, .rd_op,
        .id_free, .free_id
    );

    // two cycle read, zero data for zero spills
    scpad_sram i_scpad_sram (
        .clk, .n_rst,
        .sram_wr, .sram_wr_row, .sram_wr_data,
        .rd_strobe, .rd_row, .rd_id, .rd_dram_addr, .rd_num_bytes, .rd_op,
        .rd_done, .done_id, .done_dram_addr, .done_num_bytes, .done_rdata
    );

    dram_write_request_queue i_dram_write_request_queue (
        .clk, .n_rst,
        .rd_done, .done_id, .done_dram_addr, .done_num_bytes, .done_rdata,
        .dram_wr_req_accepted,
        .dram_write_req, .dram_addr, .dram_num_bytes, .dram_wdata,
        .id_free, .free_id
    );

endmodule

/* sim/tb_scpad_backend.sv */
`timescale 1ns/10ps

module tb_scpad_backend;

    logic                                        clk;
    logic                                        n_rst;
    logic                                        cmd_valid;
    scpad_types_pkg::scpad_op_t                  cmd_op;
    logic [scpad_types_pkg::ROW_IDX_WIDTH-1:0]   cmd_row;
    logic [scpad_types_pkg::DRAM_ADDR_WIDTH-1:0] cmd_dram_addr;
    logic [scpad_types_pkg::NUM_BYTES_WIDTH-1:0] cmd_num_bytes;
    logic                                        spill_busy;
    logic                                        sram_wr;
    logic [scpad_types_pkg::ROW_IDX_WIDTH-1:0]   sram_wr_row;
    logic [scpad_types_pkg::ROW_WIDTH-1:0]       sram_wr_data;
    logic                                        dram_write_req;
    logic [scpad_types_pkg::DRAM_ADDR_WIDTH-1:0] dram_addr;
    logic [scpad_types_pkg::NUM_BYTES_WIDTH-1:0] dram_num_bytes;
    logic [scpad_types_pkg::ROW_WIDTH-1:0]       dram_wdata;
    logic                                        dram_wr_req_accepted;

    // own copy of the scratchpad rows
    logic [scpad_types_pkg::ROW_WIDTH-1:0] rows [scpad_types_pkg::ROW_COUNT];

    // expected dram requests, command order
    logic [scpad_types_pkg::DRAM_ADDR_WIDTH-1:0] exp_addr [$];
    logic [scpad_types_pkg::NUM_BYTES_WIDTH-1:0] exp_nbytes [$];
    logic [scpad_types_pkg::ROW_WIDTH-1:0]       exp_data [$];
    // cycle count when each command was driven
    int                                          exp_cycle [$];

    int          cycle_count = 0;
    int          cycle_limit = 0;
    int          errors;
    int          checks;
    logic [31:0] lfsr_state;
    // 0 hold, 1 one in two, 2 one in eight
    int          accept_mode;
    // acceptance driven on the previous falling edge
    logic        accepted_last;

    scpad_backend i_dut (
        .clk, .n_rst,
        .cmd_valid, .cmd_op, .cmd_row, .cmd_dram_addr, .cmd_num_bytes,
        .spill_busy,
        .sram_wr, .sram_wr_row, .sram_wr_data,
        .dram_write_req, .dram_addr, .dram_num_bytes, .dram_wdata,
        .dram_wr_req_accepted
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
    end

    // run limit, set once the case file is counted
    initial begin
        wait (cycle_limit != 0);
        while (cycle_count < cycle_limit) begin
            @(posedge clk);
        end
        $display("run timed out after %0d cycles", cycle_limit);
        $display("TEST FAILED");
        $finish;
    end

    task automatic check_val(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("FAILED %s expected %0h got %0h", name, expected, actual);
        end
    endtask

    // galois lfsr, one step per bit taken
    function automatic logic next_random_bit();
        next_random_bit = lfsr_state[0];
        if (lfsr_state[0]) begin
            lfsr_state = (lfsr_state >> 1) ^ 32'h8020_0003;
        end else begin
            lfsr_state = lfsr_state >> 1;
        end
    endfunction

    function automatic logic accept_roll();
        logic [2:0] bits;
        accept_roll = 1'b0;
        if (accept_mode == 1) begin
            accept_roll = next_random_bit();
        end else if (accept_mode == 2) begin
            for (int i = 0; i < 3; i++) begin
                bits[i] = next_random_bit();
            end
            accept_roll = (bits == 3'b000);
        end
    endfunction

    // one falling edge, check outputs, then pick acceptance
    task automatic step_cycle();
        logic exp_req;
        logic exp_busy;
        logic take;
        @(negedge clk);
        cmd_valid            = 1'b0;
        sram_wr              = 1'b0;
        dram_wr_req_accepted = 1'b0;
        // an accepted id stays in use one more cycle
        exp_busy = (exp_addr.size() + accepted_last) == scpad_types_pkg::REQ_ID_COUNT;
        // command to request is four cycles through gen, sram and queue
        exp_req = (exp_addr.size() != 0) && (cycle_count >= exp_cycle[0] + 4);
        check_val("spill_busy", exp_busy, spill_busy);
        check_val("dram_write_req", exp_req, dram_write_req);
        take = 1'b0;
        if (dram_write_req && exp_req) begin
            check_val("dram_addr", exp_addr[0], dram_addr);
            check_val("dram_num_bytes", exp_nbytes[0], dram_num_bytes);
            check_val("dram_wdata", exp_data[0], dram_wdata);
            take = accept_roll();
        end
        if (take) begin
            dram_wr_req_accepted = 1'b1;
            void'(exp_addr.pop_front());
            void'(exp_nbytes.pop_front());
            void'(exp_data.pop_front());
            void'(exp_cycle.pop_front());
        end
        accepted_last = take;
    endtask

    task automatic preload_row(input int row, input logic [63:0] data);
        step_cycle();
        sram_wr      = 1'b1;
        sram_wr_row  = row[scpad_types_pkg::ROW_IDX_WIDTH-1:0];
        sram_wr_data = data;
        rows[row]    = data;
    endtask

    task automatic issue_spill(input int op, input int row, input logic [31:0] addr,
                               input int nbytes);
        step_cycle();
        // host obeys the busy level
        while (spill_busy) begin
            step_cycle();
        end
        cmd_valid     = 1'b1;
        cmd_op        = scpad_types_pkg::scpad_op_t'(op[0]);
        cmd_row       = row[scpad_types_pkg::ROW_IDX_WIDTH-1:0];
        cmd_dram_addr = addr;
        cmd_num_bytes = nbytes[scpad_types_pkg::NUM_BYTES_WIDTH-1:0];
        exp_addr.push_back(addr);
        exp_nbytes.push_back(nbytes[scpad_types_pkg::NUM_BYTES_WIDTH-1:0]);
        // zero spill skips the array
        exp_data.push_back((op == 1) ? '0 : rows[row]);
        exp_cycle.push_back(cycle_count);
    endtask

    task automatic drain_requests();
        while (exp_addr.size() != 0) begin
            step_cycle();
        end
    endtask

    initial begin
        int               fd;
        int               code;
        int               cases;
        int               op;
        int               row;
        int               nbytes;
        int               num;
        logic [7:0]       kind;
        logic [31:0]      addr;
        logic [63:0]      data;
        logic [8*160-1:0] rest;

        n_rst                = 1'b0;
        cmd_valid            = 1'b0;
        cmd_op               = scpad_types_pkg::OP_SPILL;
        cmd_row              = '0;
        cmd_dram_addr        = '0;
        cmd_num_bytes        = '0;
        sram_wr              = 1'b0;
        sram_wr_row          = '0;
        sram_wr_data         = '0;
        dram_wr_req_accepted = 1'b0;
        errors               = 0;
        checks               = 0;
        lfsr_state           = 32'h9be9_fca9;
        accept_mode          = 0;
        accepted_last        = 1'b0;

        // count spill commands first, they set the run limit
        cases = 0;
        fd = $fopen("sim/scpad_backend_cases.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("could not open sim/scpad_backend_cases.txt");
        end else begin
            while ($fscanf(fd, " %c", kind) == 1) begin
                if (kind == "S") begin
                    cases++;
                end
                code = $fgets(rest, fd);
            end
            $fclose(fd);
        end
        cycle_limit = cases * 40 + 200;

        repeat (8) @(negedge clk);
        n_rst = 1'b1;

        fd = $fopen("sim/scpad_backend_cases.txt", "r");
        if (fd != 0) begin
            while ($fscanf(fd, " %c", kind) == 1) begin
                case (kind)
                    "W": begin
                        code = $fscanf(fd, "%d %h", row, data);
                        if (code != 2) begin
                            errors++;
                            $display("malformed row preload line in the case file");
                        end else begin
                            preload_row(row, data);
                        end
                    end
                    "S": begin
                        code = $fscanf(fd, "%d %d %h %d", op, row, addr, nbytes);
                        if (code != 4) begin
                            errors++;
                            $display("malformed spill command line in the case file");
                        end else begin
                            issue_spill(op, row, addr, nbytes);
                        end
                    end
                    "A": begin
                        code = $fscanf(fd, "%d", num);
                        if (code != 1) begin
                            errors++;
                            $display("malformed accept mode line in the case file");
                        end else begin
                            accept_mode = num;
                        end
                    end
                    "C": begin
                        code = $fscanf(fd, "%d", num);
                        if (code != 1) begin
                            errors++;
                            $display("malformed idle cycle line in the case file");
                        end else begin
                            repeat (num) step_cycle();
                        end
                    end
                    "D": drain_requests();
                    "#": code = $fgets(rest, fd);
                    default: begin
                        errors++;
                        $display("unknown line kind %c in the case file", kind);
                        code = $fgets(rest, fd);
                    end
                endcase
            end
            $fclose(fd);
        end

        // anything left goes out under steady acceptance
        accept_mode = 1;
        drain_requests();
        repeat (4) step_cycle();

        $display("checks %0d errors %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* sim/scpad_backend_cases.txt */
# W row data, S op row addr nbytes (op 0 copy, 1 zeros), data and addr in hex
# A accept mode (0 hold, 1 one in two, 2 one in eight), C idle cycles, D drain
C 12
W 1 0123456789abcdef
W 2 fedcba9876543210
W 3 a5a55a5a0f0ff0f0
W 4 1122334455667788
A 1
S 0 1 00001000 8
D
S 1 3 00002040 5
D
S 0 2 00003000 8
S 0 4 00003008 6
S 1 3 00003010 3
C 6
S 0 3 00003018 8
S 0 1 00003020 1
S 0 2 00003028 0
D
A 0
S 0 1 00004000 8
S 0 2 00004008 7
S 0 3 00004010 6
S 0 4 00004018 5
S 1 1 00004020 4
S 0 2 00004028 3
S 0 3 00004030 2
S 0 4 00004038 1
C 6
A 2
S 0 1 00004040 8
W 4 0badc0de00c0ffee
S 0 4 00005000 8
D

/* scpad_backend.f */
common/scpad_types_pkg.sv
hdl/scpad_sram.sv
hdl/spill_req_gen.sv
dram_wr_queue/dram_write_request_queue.sv
hdl/scpad_backend.sv
sim/tb_scpad_backend.sv

/* Bender.yml */
package:
  name: scpad_backend

sources:
  # shared package first
  - common/scpad_types_pkg.sv
  # design sources
  - hdl/scpad_sram.sv
  - hdl/spill_req_gen.sv
  - dram_wr_queue/dram_write_request_queue.sv
  - hdl/scpad_backend.sv
  # testbench
  - target: simulation
    files:
      - sim/tb_scpad_backend.sv
